// ==== hw/heapGeometryPkg.sv ====
/* Geometry of the array heap: pool size, element width and queue depths.
   Every block that stores, indexes or counts heap data imports it. */
package heapGeometryPkg;

  localparam int ARRAY_BITS       = 2;                  // Bits in an array number
  localparam int INDEX_BITS       = 3;                  // Bits in an element index
  localparam int ARRAY_LENGTH     = 1 << INDEX_BITS;    // Elements per array
  localparam int ARRAYS           = 1 << ARRAY_BITS;    // Arrays in the pool
  localparam int DATA_BITS        = 12;                 // Element width
  localparam int COMMAND_DEPTH    = 4;                  // Also the requester's first credits
  localparam int RESPONSE_DEPTH   = 4;
  localparam int RESPONSE_CREDITS = 2;                  // Consumer slots after reset
  localparam int COUNT_BITS       = 3;                  // Holds 0 to either depth

  typedef logic [ARRAY_BITS-1:0] arrayIdT;
  typedef logic [INDEX_BITS-1:0] indexT;
  typedef logic [INDEX_BITS:0]   sizeT;                 // 0 to ARRAY_LENGTH
  typedef logic [DATA_BITS-1:0]  dataT;
  typedef dataT [ARRAY_LENGTH-1:0] rowT;                // One whole array
  typedef logic [COUNT_BITS-1:0] countT;                // Queue entries and credits

endpackage

// ==== hw/heapCommandPkg.sv ====
/* Command set of the array heap and the words passed between its stages.
   Used by the RTL and the testbench to build and decode commands. */
package heapCommandPkg;

  typedef enum logic [3:0] {
    opAlloc,                                            // Take a freed or fresh array
    opFree,
    opWrite,                                            // May grow the array
    opRead,
    opSize,
    opPush,
    opPop,
    opLess,                                             // Count below key
    opGreater,                                          // Count above key
    opIndex                                             // Last match plus one
  } heapOpT;

  typedef enum logic [2:0] {
    errNone,
    errUnallocated,                                     // Never allocated or already freed
    errBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } heapErrorT;

  typedef struct packed {
    heapOpT                   op;
    heapGeometryPkg::arrayIdT array;
    heapGeometryPkg::indexT   index;
    heapGeometryPkg::dataT    data;                     // Write data or scan key
  } heapCommandT;

  typedef struct packed {
    heapGeometryPkg::dataT data;
    heapErrorT             error;
  } heapResponseT;

  // Registered verdict of the array table for one command
  typedef struct packed {
    heapErrorT                error;
    heapGeometryPkg::sizeT    oldSize;                  // Size before this command
    heapGeometryPkg::arrayIdT newId;                    // Alloc result
    heapGeometryPkg::indexT   slot;                     // Element touched
    logic                     write;                    // Element write-back due
  } tableStatusT;

endpackage

// ==== hw/heapStageIf.sv ====
/* Stage buses inside the heap: command issue, table verdict and the
   element row with its write-back path. */
`timescale 1ns/10ps

interface issueIf;
  import heapCommandPkg::*;

  logic        headValid;                               // Command queue not empty
  heapCommandT command;                                 // Queue head
  logic        valid;                                   // Issue and pop this cycle

  modport issuer (input headValid, input command, output valid);
  modport listener (input valid, input command);
endinterface

interface tableIf;
  import heapCommandPkg::*;

  logic        valid;                                   // One cycle after issue
  tableStatusT result;

  modport source (output valid, output result);
  modport sink (input valid, input result);
endinterface

interface storeIf;
  import heapGeometryPkg::*;

  rowT     row;                                         // Registered array row
  logic    writeEnable;
  arrayIdT writeArray;
  indexT   writeSlot;
  dataT    writeData;

  modport memory (output row, input writeEnable, input writeArray, input writeSlot,
                  input writeData);
  modport merge (input row, output writeEnable, output writeArray, output writeSlot,
                 output writeData);
endinterface

// ==== hw/creditQueue.sv ====
/* Small circular FIFO for any payload type. A push shows at the head on the
   next cycle, and freeCount tells the producer how much room is left. */
`timescale 1ns/10ps

module creditQueue #(
  parameter type payloadT = logic,
  parameter int  DEPTH    = 4
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   pushValid,
  input  payloadT                pushData,
  input  logic                   popReady,
  output logic                   headValid,
  output payloadT                headData,
  output heapGeometryPkg::countT freeCount
);
  import heapGeometryPkg::*;

  payloadT                  entries [DEPTH];            // Storage ring
  logic [$clog2(DEPTH)-1:0] readPtr;
  logic [$clog2(DEPTH)-1:0] writePtr;
  countT                    count;                      // Entries held
  logic                     popping;

  assign popping   = popReady && headValid;             // Never pop an empty queue
  assign headValid = count != '0;
  assign headData  = entries[readPtr];
  assign freeCount = countT'(DEPTH) - count;

  //----------------------------------------------------------------------
  // Pointers and fill level
  //----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      readPtr  <= '0;
      writePtr <= '0;
      count    <= '0;
    end else begin
      if (pushValid) begin
        writePtr <= (writePtr == DEPTH - 1) ? '0 : writePtr + 1'b1;
      end
      if (popping) begin
        readPtr <= (readPtr == DEPTH - 1) ? '0 : readPtr + 1'b1;
      end
      count <= count + countT'(pushValid) - countT'(popping);  // Both may happen at once
    end
  end

  always_ff @(posedge clock) begin
    if (pushValid) begin
      entries[writePtr] <= pushData;
    end
  end

endmodule

// ==== hw/arrayTable.sv ====
/* Bookkeeping side of the heap: allocation flags, sizes and the free stack.
   Checks each issued command and registers its verdict one cycle later. */
`timescale 1ns/10ps

module arrayTable (
  input logic      clock,
  input logic      resetN,
  issueIf.listener issue,
  tableIf.source   status
);
  import heapGeometryPkg::*;
  import heapCommandPkg::*;

  logic [ARRAYS-1:0]   allocated;                       // One flag per array
  sizeT                sizes [ARRAYS];
  arrayIdT             freeStack [ARRAYS];              // Last freed on top
  logic [ARRAY_BITS:0] freeTop;
  logic [ARRAY_BITS:0] neverUsed;                       // Fresh arrays left
  arrayIdT             stackTop;
  heapCommandT         command;
  tableStatusT         next;
  logic                grows;                           // Write beyond current size
  logic                accepted;

  assign command  = issue.command;
  assign stackTop = arrayIdT'(freeTop - 1'b1);
  assign grows    = sizeT'(command.index) >= sizes[command.array];
  assign accepted = issue.valid && next.error == errNone;

  //----------------------------------------------------------------------
  // Checks and verdict
  //----------------------------------------------------------------------
  always_comb begin
    next.error   = errNone;
    next.oldSize = sizes[command.array];
    next.newId   = arrayIdT'(ARRAYS - neverUsed);       // Next fresh array
    next.slot    = command.index;
    if (command.op == opAlloc) begin
      if (freeTop != '0) next.newId = freeStack[stackTop];  // Reuse freed first
      else if (neverUsed == '0) next.error = errOutOfMemory;
    end else if (!allocated[command.array]) begin
      next.error = errUnallocated;                      // Also catches double free
    end else begin
      case (command.op)
        opRead:  if (grows) next.error = errBounds;
        opWrite: if (grows && next.oldSize == ARRAY_LENGTH) next.error = errFull;
        opPush:  if (next.oldSize == ARRAY_LENGTH) next.error = errFull;
        opPop:   if (next.oldSize == '0) next.error = errEmpty;
        default: ;
      endcase
    end
    if (command.op == opPush) next.slot = indexT'(next.oldSize);          // Append slot
    if (command.op == opPop) next.slot = indexT'(next.oldSize - 1'b1);    // Top slot
    next.write = (command.op == opWrite || command.op == opPush) && next.error == errNone;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated    <= '0;
      freeTop      <= '0;
      neverUsed    <= (ARRAY_BITS + 1)'(ARRAYS);
      status.valid <= 1'b0;
    end else begin
      status.valid <= issue.valid;
      if (accepted && command.op == opAlloc) begin
        allocated[next.newId] <= 1'b1;
        if (freeTop != '0) freeTop <= freeTop - 1'b1;
        else neverUsed <= neverUsed - 1'b1;
      end
      if (accepted && command.op == opFree) begin
        allocated[command.array] <= 1'b0;
        freeTop                  <= freeTop + 1'b1;
      end
    end
  end

  //----------------------------------------------------------------------
  // Sizes, stack slots and the registered verdict
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (issue.valid) status.result <= next;
    if (accepted) begin
      case (command.op)
        opAlloc: sizes[next.newId] <= '0;               // Fresh or reused starts empty
        opFree:  freeStack[freeTop[ARRAY_BITS-1:0]] <= command.array;
        opWrite: if (grows) sizes[command.array] <= sizeT'(command.index) + 1'b1;
        opPush:  sizes[command.array] <= next.oldSize + 1'b1;
        opPop:   sizes[command.array] <= next.oldSize - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== hw/elementStore.sv ====
/* Element memory of the heap. Registers the whole row of the issued array
   and writes single elements back from the response stage. */
`timescale 1ns/10ps

module elementStore (
  input logic      clock,
  input logic      resetN,
  issueIf.listener issue,
  storeIf.memory   store
);
  import heapGeometryPkg::*;

  rowT rows [ARRAYS];                                   // All arrays
  rowT readRow;                                         // Row with bypass applied
  logic bypass;

  // Write-back in the same cycle as a read of that array
  assign bypass = store.writeEnable && store.writeArray == issue.command.array;

  always_comb begin
    readRow = rows[issue.command.array];
    if (bypass) readRow[store.writeSlot] = store.writeData;  // Newest element wins
  end

  //----------------------------------------------------------------------
  // Row register and element write
  //----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      store.row <= '0;
    end else if (issue.valid) begin
      store.row <= readRow;                             // Ready one cycle after issue
    end
  end

  always_ff @(posedge clock) begin
    if (store.writeEnable) begin
      rows[store.writeArray][store.writeSlot] <= store.writeData;
    end
  end

endmodule

// ==== hw/responseMerge.sv ====
/* Response stage of the heap. Gates issue on response queue room, builds
   each response from the table verdict and row, and spends response credits. */
`timescale 1ns/10ps

module responseMerge (
  input  logic                          clock,
  input  logic                          resetN,
  issueIf.issuer                        issue,
  tableIf.sink                          status,
  storeIf.merge                         store,
  input  heapGeometryPkg::countT        queueFree,
  output logic                          responsePush,
  output heapCommandPkg::heapResponseT  response,
  input  logic                          responseCredit,
  output logic                          responsePop,
  input  logic                          responseAvailable
);
  import heapGeometryPkg::*;
  import heapCommandPkg::*;

  logic        inFlight;                                // Command in table stage
  heapCommandT flight;                                  // Its op, array and key
  countT       credits;
  sizeT        lessCount;
  sizeT        greaterCount;
  sizeT        lastMatch;

  // Room for this push and the one after it
  assign issue.valid  = issue.headValid && queueFree > countT'(inFlight);
  assign responsePush = status.valid;
  assign responsePop  = responseAvailable && credits != '0;

  //----------------------------------------------------------------------
  // Scans over the used part of the row
  //----------------------------------------------------------------------
  always_comb begin
    lessCount    = '0;
    greaterCount = '0;
    lastMatch    = '0;
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      if (i < status.result.oldSize) begin
        if (store.row[i] < flight.data) lessCount = lessCount + 1'b1;
        if (store.row[i] > flight.data) greaterCount = greaterCount + 1'b1;
        if (store.row[i] == flight.data) lastMatch = sizeT'(i + 1);  // Later match wins
      end
    end
  end

  always_comb begin
    response.error = status.result.error;
    case (flight.op)
      opWrite, opPush: response.data = flight.data;    // Echo written value
      opRead, opPop:   response.data = store.row[status.result.slot];
      opSize:          response.data = dataT'(status.result.oldSize);
      opLess:          response.data = dataT'(lessCount);
      opGreater:       response.data = dataT'(greaterCount);
      opIndex:         response.data = dataT'(lastMatch);
      opAlloc:         response.data = dataT'(status.result.newId);
      default:         response.data = '0;             // Free
    endcase
    if (status.result.error != errNone) response.data = '0;
  end

  // Lands at the end of the push cycle
  assign store.writeEnable = status.valid && status.result.write;
  assign store.writeArray  = flight.array;
  assign store.writeSlot   = status.result.slot;
  assign store.writeData   = flight.data;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      inFlight <= 1'b0;
      credits  <= countT'(RESPONSE_CREDITS);
    end else begin
      inFlight <= issue.valid;
      credits  <= credits - countT'(responsePop) + countT'(responseCredit);
    end
  end

  always_ff @(posedge clock) begin
    if (issue.valid) flight <= issue.command;
  end

endmodule

// ==== hw/heapMemory.sv ====
/* Top level of the array heap. Commands enter a credit queue, pass the array
   table and element store side by side, and leave through a response queue. */
`timescale 1ns/10ps

module heapMemory (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       commandValid,
  input  heapCommandPkg::heapOpT     commandOp,
  input  heapGeometryPkg::arrayIdT   commandArray,
  input  heapGeometryPkg::indexT     commandIndex,
  input  heapGeometryPkg::dataT      commandData,
  output logic                       commandCredit,
  output logic                       responseValid,
  output heapGeometryPkg::dataT      responseData,
  output heapCommandPkg::heapErrorT  responseError,
  input  logic                       responseCredit
);
  import heapGeometryPkg::*;
  import heapCommandPkg::*;

  heapCommandT  commandWord;
  heapResponseT responseWord;                           // From the merge stage
  heapResponseT responseHead;                           // Oldest waiting response
  logic         responsePush;
  logic         responsePop;
  logic         responseAvailable;
  countT        responseFree;

  issueIf issueBus ();
  tableIf tableBus ();
  storeIf storeBus ();

  assign commandWord   = '{op: commandOp, array: commandArray, index: commandIndex,
                           data: commandData};
  assign commandCredit = issueBus.valid;                // Credit back on each pop
  assign responseValid = responsePop;
  assign responseData  = responseHead.data;
  assign responseError = responseHead.error;

  //----------------------------------------------------------------------
  // Queues and stages
  //----------------------------------------------------------------------
  creditQueue #(.payloadT(heapCommandT), .DEPTH(COMMAND_DEPTH)) commandQueue (
    .clock     (clock),
    .resetN    (resetN),
    .pushValid (commandValid),
    .pushData  (commandWord),
    .popReady  (issueBus.valid),
    .headValid (issueBus.headValid),
    .headData  (issueBus.command),
    .freeCount ()
  );

  creditQueue #(.payloadT(heapResponseT), .DEPTH(RESPONSE_DEPTH)) responseQueue (
    .clock     (clock),
    .resetN    (resetN),
    .pushValid (responsePush),
    .pushData  (responseWord),
    .popReady  (responsePop),
    .headValid (responseAvailable),
    .headData  (responseHead),
    .freeCount (responseFree)
  );

  arrayTable arrayTable (
    .clock  (clock),
    .resetN (resetN),
    .issue  (issueBus),
    .status (tableBus)
  );

  elementStore elementStore (
    .clock  (clock),
    .resetN (resetN),
    .issue  (issueBus),
    .store  (storeBus)
  );

  responseMerge responseMerge (
    .clock             (clock),
    .resetN            (resetN),
    .issue             (issueBus),
    .status            (tableBus),
    .store             (storeBus),
    .queueFree         (responseFree),
    .responsePush      (responsePush),
    .response          (responseWord),
    .responseCredit    (responseCredit),
    .responsePop       (responsePop),
    .responseAvailable (responseAvailable)
  );

endmodule

// ==== tb/heapMemory_properties.sv ====
/* Credit and reset rules of the heap top level, bound into every instance.
   Keeps its own credit counts from the top-level ports. */
`timescale 1ns/10ps

module heapMemoryProperties (
  input logic clock,
  input logic resetN,
  input logic commandValid,
  input logic commandCredit,
  input logic responseValid,
  input logic responseCredit
);
  import heapGeometryPkg::*;

  int commandsIn;                                       // Commands pushed so far
  int creditsOut;                                       // commandCredit pulses so far
  int creditsHeld;                                      // Response credits left

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      commandsIn  <= 0;
      creditsOut  <= 0;
      creditsHeld <= RESPONSE_CREDITS;
    end else begin
      commandsIn  <= commandsIn + int'(commandValid);
      creditsOut  <= creditsOut + int'(commandCredit);
      creditsHeld <= creditsHeld - int'(responseValid) + int'(responseCredit);
    end
  end

  //----------------------------------------------------------------------
  // Credit rules
  //----------------------------------------------------------------------
  responseNeedsCredit: assert property (@(posedge clock) disable iff (!resetN)
    responseValid |-> creditsHeld > 0)
    else $error("responseValid fired with no response credit left");

  // A pulse frees a command pushed in an earlier cycle
  creditFollowsCommand: assert property (@(posedge clock) disable iff (!resetN)
    commandCredit |-> creditsOut < commandsIn)
    else $error("more commandCredit pulses than commands accepted");

  quietInReset: assert property (@(posedge clock)
    !resetN |-> !responseValid && !commandCredit)
    else $error("handshake output high during reset");

endmodule

bind heapMemory heapMemoryProperties heapMemoryChecks (
  .clock          (clock),
  .resetN         (resetN),
  .commandValid   (commandValid),
  .commandCredit  (commandCredit),
  .responseValid  (responseValid),
  .responseCredit (responseCredit)
);

// ==== tb/heapMemoryTb.sv ====
/* Testbench for the array heap. Runs directed allocation, access, stack and
   scan phases, a random stream and a back-pressure stretch, and checks each
   response in order against a reference model of the heap. */
`timescale 1ns/10ps

module heapMemoryTb;
  import heapGeometryPkg::*;
  import heapCommandPkg::*;

  localparam int WAIT_LIMIT = 200;                      // Cycles allowed per wait

  logic      clock = 1'b0;
  logic      resetN;
  logic      commandValid;
  heapOpT    commandOp;
  arrayIdT   commandArray;
  indexT     commandIndex;
  dataT      commandData;
  logic      commandCredit;
  logic      responseValid;
  dataT      responseData;
  heapErrorT responseError;
  logic      responseCredit;

  logic [31:0]  lfsr = 32'h7a19_c913;
  heapResponseT expected [$];                           // Model responses in command order
  string        testName;
  int           sent = 0;
  int           creditsBack = 0;                        // commandCredit pulses seen
  int           received = 0;
  int           returned = 0;                           // Response credits handed back
  bit           holdCredits = 1'b0;

  logic    modelAllocated [ARRAYS];                     // Reference heap state
  int      modelSize [ARRAYS];
  arrayIdT modelFree [$];                               // Last freed at the back
  int      modelFresh = ARRAYS;
  dataT    modelStore [ARRAYS][ARRAY_LENGTH];

  heapMemory heapMemory_inst (.*);

  always #10 clock = ~clock;

  function automatic logic [31:0] lfsrStep(logic [31:0] state);
    return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
  endfunction

  function automatic logic [31:0] takeBits(int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsrStep(lfsr);                           // One step per bit
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  //----------------------------------------------------------------------
  // Reference model, applied in command order
  //----------------------------------------------------------------------
  function automatic heapResponseT reference(heapOpT op, arrayIdT array, indexT index,
                                             dataT data);
    heapResponseT result;
    arrayIdT      id;
    int           size;
    result = '{data: '0, error: errNone};
    size   = modelSize[array];
    if (op == opAlloc) begin
      if (modelFree.size() > 0) begin
        id = modelFree.pop_back();                      // Last freed first
      end else if (modelFresh > 0) begin
        id         = arrayIdT'(ARRAYS - modelFresh);
        modelFresh = modelFresh - 1;
      end else begin
        result.error = errOutOfMemory;
      end
      if (result.error == errNone) begin
        modelAllocated[id] = 1'b1;
        modelSize[id]      = 0;
        result.data        = dataT'(id);
      end
    end else if (!modelAllocated[array]) begin
      result.error = errUnallocated;
    end else begin
      case (op)
        opFree: begin
          modelAllocated[array] = 1'b0;
          modelFree.push_back(array);
        end
        opWrite: begin
          modelStore[array][index] = data;              // Index is below the length
          if (index >= size) modelSize[array] = index + 1;
          result.data = data;
        end
        opRead:  if (index >= size) result.error = errBounds;
                 else result.data = modelStore[array][index];
        opSize:  result.data = dataT'(size);
        opPush:  if (size == ARRAY_LENGTH) result.error = errFull;
                 else begin
                   modelStore[array][size] = data;
                   modelSize[array]        = size + 1;
                   result.data             = data;
                 end
        opPop:   if (size == 0) result.error = errEmpty;
                 else begin
                   modelSize[array] = size - 1;
                   result.data      = modelStore[array][size-1];
                 end
        default: for (int i = 0; i < size; i++) begin  // Scans over the used part
          if (op == opLess && modelStore[array][i] < data) result.data++;
          if (op == opGreater && modelStore[array][i] > data) result.data++;
          if (op == opIndex && modelStore[array][i] == data) result.data = dataT'(i + 1);
        end
      endcase
    end
    return result;
  endfunction

  //----------------------------------------------------------------------
  // Failure reporting and compares
  //----------------------------------------------------------------------
  task automatic reportFailure(string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic checkData(string name, dataT expectedValue, dataT actual);
    if (actual !== expectedValue)
      reportFailure($sformatf("MISMATCH %s: expected data %0d, actual %0d", name,
                              expectedValue, actual));
  endtask

  task automatic checkError(string name, heapErrorT expectedValue, heapErrorT actual);
    if (actual !== expectedValue)
      reportFailure($sformatf("MISMATCH %s: expected error %s, actual %s (%0d)", name,
                              expectedValue.name(), actual.name(), actual));
  endtask

  // Outputs come straight from registers and hold steady up to the rising edge
  always @(posedge clock) begin
    heapResponseT want;
    if (resetN) begin
      if (commandCredit) creditsBack++;
      if (responseValid) begin
        received++;
        if (expected.size() == 0) reportFailure("A response came with no command waiting");
        want = expected.pop_front();
        checkData(testName, want.data, responseData);
        checkError(testName, want.error, responseError);
      end
    end
  end

  //----------------------------------------------------------------------
  // Stimulus on the falling edge
  //----------------------------------------------------------------------
  task automatic nextCycle();
    @(negedge clock);
    commandValid   = 1'b0;
    responseCredit = 1'b0;
    if (!holdCredits && returned < received && takeBits(1)) begin
      responseCredit = 1'b1;                            // Hand back one consumed slot
      returned++;
    end
  endtask

  task automatic drive(heapOpT op, arrayIdT array, indexT index, dataT data);
    commandValid = 1'b1;
    commandOp    = op;
    commandArray = array;
    commandIndex = index;
    commandData  = data;
    expected.push_back(reference(op, array, index, data));
    sent++;
  endtask

  task automatic send(heapOpT op, arrayIdT array, indexT index, dataT data);
    int waited;
    waited = 0;
    nextCycle();
    while (sent - creditsBack >= COMMAND_DEPTH) begin  // Out of command credits
      waited++;
      if (waited > WAIT_LIMIT) reportFailure("No command credit came back in time");
      nextCycle();
    end
    drive(op, array, index, data);
  endtask

  task automatic drain();
    int waited;
    int lastReceived;
    waited       = 0;
    lastReceived = received;
    while (received < sent || returned < received) begin
      if (received != lastReceived) begin
        lastReceived = received;                        // Each response restarts the limit
        waited       = 0;
      end
      waited++;
      if (waited > WAIT_LIMIT)
        reportFailure("Responses stopped before all commands were answered");
      nextCycle();
    end
  endtask

  initial begin
    int      code;
    arrayIdT array;
    indexT   slot;
    dataT    key;
    int      creditMark;
    int      startResponses;
    resetN         = 1'b0;
    commandValid   = 1'b0;
    commandOp      = opAlloc;
    commandArray   = '0;
    commandIndex   = '0;
    commandData    = '0;
    responseCredit = 1'b0;
    array          = '0;
    for (int a = 0; a < ARRAYS; a++) begin
      modelAllocated[a] = 1'b0;
      modelSize[a]      = 0;
    end
    repeat (10) @(negedge clock);
    resetN = 1'b1;

    testName = "allocation";                            // Ids 0 to 3 and then out of memory
    repeat (ARRAYS + 1) send(opAlloc, '0, '0, '0);
    for (int a = 0; a < ARRAYS; a++)                    // Every element gets a known value
      for (int i = 0; i < ARRAY_LENGTH; i++)
        send(opWrite, arrayIdT'(a), indexT'(i), dataT'(a * 97 + i * 13 + 5));
    send(opFree, 2'd2, '0, '0);
    send(opFree, 2'd1, '0, '0);
    repeat (2) send(opAlloc, '0, '0, '0);               // Reuse 1 then 2
    send(opFree, 2'd3, '0, '0);
    send(opFree, 2'd3, '0, '0);                         // Double free
    drain();

    testName = "writeReadSize";
    for (int i = 0; i < 3; i++) send(opWrite, 2'd1, indexT'(i), dataT'(100 + i));
    for (int i = 0; i < 3; i++) send(opRead, 2'd1, indexT'(i), '0);
    send(opRead, 2'd1, 3'd5, '0);
    send(opSize, 2'd1, '0, '0);
    send(opRead, 2'd3, '0, '0);                         // Freed array
    send(opWrite, 2'd3, 3'd1, 12'd7);
    send(opSize, 2'd3, '0, '0);
    drain();

    testName = "pushPop";
    for (int i = 0; i <= ARRAY_LENGTH; i++) send(opPush, 2'd2, '0, dataT'(200 + i));
    for (int i = 0; i <= ARRAY_LENGTH; i++) send(opPop, 2'd2, '0, '0);
    drain();

    testName = "scans";
    for (int i = 1; i <= 3; i++) send(opPush, 2'd2, '0, dataT'(10 * i));
    send(opLess, 2'd2, '0, 12'd20);
    send(opGreater, 2'd2, '0, 12'd20);
    send(opIndex, 2'd2, '0, 12'd20);
    send(opIndex, 2'd2, '0, 12'd25);                    // No match
    drain();

    testName = "randomStream";
    for (int n = 0; n < 400; n++) begin
      code = takeBits(4);
      if (code > 9) code = code - 8;                    // Fold spare codes onto accesses
      if (!takeBits(1)) array = arrayIdT'(takeBits(ARRAY_BITS));  // Else same array again
      slot = indexT'(takeBits(INDEX_BITS));
      key  = takeBits(1) ? dataT'(takeBits(4)) : dataT'(takeBits(DATA_BITS));
      send(heapOpT'(code), array, slot, key);
    end
    drain();

    testName       = "backPressure";
    holdCredits    = 1'b1;
    startResponses = received;
    creditMark     = 0;
    for (int c = 0; c < 60; c++) begin
      nextCycle();
      if (sent - creditsBack < COMMAND_DEPTH) drive(opRead, array, indexT'(c), '0);
      if (c == 40) creditMark = creditsBack;            // Queues long full by now
    end
    if (received - startResponses > RESPONSE_CREDITS)
      reportFailure("More responses came out than response credits allowed");
    if (creditsBack != creditMark)
      reportFailure("commandCredit kept pulsing after the queues were full");
    holdCredits = 1'b0;
    drain();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== heapMemory.f ====
hw/heapGeometryPkg.sv
hw/heapCommandPkg.sv
hw/heapStageIf.sv
hw/creditQueue.sv
hw/arrayTable.sv
hw/elementStore.sv
hw/responseMerge.sv
hw/heapMemory.sv
tb/heapMemory_properties.sv
tb/heapMemoryTb.sv

// ==== Bender.yml ====
package:
  name: heap_memory

sources:
  - hw/heapGeometryPkg.sv
  - hw/heapCommandPkg.sv
  - hw/heapStageIf.sv
  - hw/creditQueue.sv
  - hw/arrayTable.sv
  - hw/elementStore.sv
  - hw/responseMerge.sv
  - hw/heapMemory.sv
  - target: simulation
    files:
      - tb/heapMemory_properties.sv
      - tb/heapMemoryTb.sv
